// File: acc_pkg.sv
package acc_pkg;

  // ************************************************************
  // field widths
  // ************************************************************
  localparam int ADDR_W = 32;
  localparam int QTD_W = 16;
  localparam int QID_W = 8;
  localparam int TAG_W = 8;
  localparam int DATA_W = 64;

  typedef logic [ADDR_W-1:0] addr_t;  // one cache line per address.
  typedef logic [QTD_W-1:0] qtd_t;
  typedef logic [QID_W-1:0] qid_t;
  typedef logic [TAG_W-1:0] tag_t;  // a tag is the queue id.
  typedef logic [DATA_W-1:0] data_t;
  typedef logic [ADDR_W+QTD_W+QID_W-1:0] conf_t;
  typedef logic [1:0] conf_cmd_t;

  localparam conf_cmd_t CONF_LOAD = 2'd1;

  // ************************************************************
  // configuration word layout, address on top, queue id at bit 0
  // ************************************************************
  localparam int CONF_QID_LSB = 0;
  localparam int CONF_QTD_LSB = CONF_QID_LSB + QID_W;
  localparam int CONF_ADDR_LSB = CONF_QTD_LSB + QTD_W;

endpackage

// File: input_queue_controller.sv
`timescale 1ns/1ps

module input_queue_controller #(
  parameter int ID_QUEUE = 0,
  parameter int FIFO_DEPTH_BITS = 4
) (
  input  logic clk,
  input  logic rst,
  input  logic start,
  input  acc_pkg::conf_cmd_t conf_valid,
  input  acc_pkg::conf_t conf,
  input  logic rd_valid,
  input  acc_pkg::tag_t rd_tag,
  input  acc_pkg::data_t rd_data,
  input  logic user_rd_en,
  mem_rd_if.queue req,
  output logic user_avail,
  output acc_pkg::data_t user_data,
  output logic user_valid,
  output logic done
);

  localparam int FIFO_DEPTH = 2 ** FIFO_DEPTH_BITS;
  localparam acc_pkg::qid_t QID = acc_pkg::qid_t'(ID_QUEUE);
  localparam acc_pkg::tag_t TAG = acc_pkg::tag_t'(ID_QUEUE);

  acc_pkg::conf_t conf_reg;
  logic conf_read;
  logic conf_ready;
  logic addr_init;
  acc_pkg::addr_t addr_base;
  acc_pkg::addr_t addr_next;
  acc_pkg::qtd_t qtd_lines;
  acc_pkg::qtd_t count_req;
  acc_pkg::qtd_t count_rcv;
  logic [FIFO_DEPTH_BITS:0] outstanding;
  logic [FIFO_DEPTH_BITS+1:0] occupancy;
  logic fifo_we;
  acc_pkg::data_t fifo_din;
  logic [FIFO_DEPTH_BITS:0] fifo_count;
  logic fifo_empty;
  logic fifo_almostempty;
  logic configured;
  logic all_requested;
  logic fifo_fit;
  logic issue;
  logic rd_match;

  sync_fifo #(
    .FIFO_DEPTH_BITS(FIFO_DEPTH_BITS),
    .ALMOSTFULL_THRESHOLD(FIFO_DEPTH - 4),
    .ALMOSTEMPTY_THRESHOLD(2)
  ) u_fifo (
    .clk(clk),
    .rst(rst),
    .we(fifo_we),
    .din(fifo_din),
    .re(user_rd_en),
    .valid(user_valid),
    .dout(user_data),
    .count(fifo_count),
    .empty(fifo_empty),
    .full(),
    .almostfull(),
    .almostempty(fifo_almostempty)
  );

  assign configured = conf_ready && !addr_init;  // base address is loaded.
  assign all_requested = (count_req >= qtd_lines);
  assign occupancy = {1'b0, outstanding} + {1'b0, fifo_count};
  assign fifo_fit = (occupancy < FIFO_DEPTH);  // every outstanding read has a slot.
  assign issue = start && configured && !all_requested && req.available_read &&
                 fifo_fit && !req.request_read;
  assign rd_match = rd_valid && (rd_tag == TAG);
  assign done = start && conf_ready && (count_rcv >= qtd_lines) && (outstanding == '0);

  // near empty, a read in this cycle may take the last line.
  assign user_avail = fifo_almostempty ? (!fifo_empty && !user_rd_en) : 1'b1;

  // ************************************************************
  // configuration capture and id filter
  // ************************************************************
  always_ff @(posedge clk) begin
    if (conf_valid == acc_pkg::CONF_LOAD) begin
      conf_reg <= conf;
    end
    if (conf_read && (conf_reg[acc_pkg::CONF_QID_LSB +: acc_pkg::QID_W] == QID)) begin
      addr_base <= conf_reg[acc_pkg::CONF_ADDR_LSB +: acc_pkg::ADDR_W];
      qtd_lines <= conf_reg[acc_pkg::CONF_QTD_LSB +: acc_pkg::QTD_W];
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      conf_read <= 1'b0;
      conf_ready <= 1'b0;
    end else begin
      conf_read <= (conf_valid == acc_pkg::CONF_LOAD);
      if (conf_read && (conf_reg[acc_pkg::CONF_QID_LSB +: acc_pkg::QID_W] == QID)) begin
        conf_ready <= 1'b1;
      end
    end
  end

  // ************************************************************
  // request side
  // ************************************************************
  always_ff @(posedge clk) begin
    if (rst) begin
      addr_init <= 1'b1;
      count_req <= '0;
      req.request_read <= 1'b0;
    end else begin
      req.request_read <= issue;
      if (conf_ready && addr_init) begin
        addr_next <= addr_base;
        addr_init <= 1'b0;
      end else if (req.request_read) begin
        addr_next <= addr_next + 1'b1;  // lines are consecutive.
        count_req <= count_req + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (issue) begin
      req.request_data <= {addr_next, TAG};
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      outstanding <= '0;
      req.has_pending <= 1'b0;
    end else begin
      req.has_pending <= (outstanding != '0);
      case ({fifo_we, req.request_read})
        2'b01: outstanding <= outstanding + 1'b1;
        2'b10: outstanding <= outstanding - 1'b1;
        default: outstanding <= outstanding;
      endcase
    end
  end

  // ************************************************************
  // response side
  // ************************************************************
  always_ff @(posedge clk) begin
    if (rst) begin
      fifo_we <= 1'b0;
      count_rcv <= '0;
    end else begin
      fifo_we <= rd_match;
      if (rd_match) begin
        count_rcv <= count_rcv + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rd_match) begin
      fifo_din <= rd_data;
    end
  end

endmodule

// File: mem_rd_if.sv
`timescale 1ns/1ps

interface mem_rd_if;

  logic available_read;  // grant from the arbiter.
  logic request_read;  // one-cycle strobe.
  logic [acc_pkg::ADDR_W+acc_pkg::TAG_W-1:0] request_data;  // address above tag.
  logic has_pending;

  modport queue (
    input  available_read,
    output request_read,
    output request_data,
    output has_pending
  );

  modport arb (
    output available_read,
    input  request_read,
    input  request_data,
    input  has_pending
  );

endinterface

// File: rd_req_arbiter.sv
`timescale 1ns/1ps

module rd_req_arbiter #(
  parameter int NUM_QUEUES = 2
) (
  input  logic clk,
  input  logic rst,
  input  logic mem_ready,
  mem_rd_if.arb req [NUM_QUEUES],
  output logic mem_req_valid,
  output acc_pkg::addr_t mem_req_addr,
  output acc_pkg::tag_t mem_req_tag
);

  localparam int PTR_W = (NUM_QUEUES > 1) ? $clog2(NUM_QUEUES) : 1;
  localparam int REQ_W = acc_pkg::ADDR_W + acc_pkg::TAG_W;

  logic [PTR_W-1:0] ptr;
  logic [PTR_W-1:0] cand;
  logic [PTR_W-1:0] ptr_next;
  logic [NUM_QUEUES-1:0] gnt_vec;
  logic [NUM_QUEUES-1:0] gnt_q;
  logic [NUM_QUEUES-1:0] req_vec;
  logic [NUM_QUEUES-1:0] pend_vec;
  logic [NUM_QUEUES-1:0] unused;
  logic [NUM_QUEUES-1:0] unused_now;
  logic [NUM_QUEUES-1:0] cand_mask;
  logic [REQ_W-1:0] req_data [NUM_QUEUES];
  logic [REQ_W-1:0] req_mux;
  logic skip;

  function automatic logic [PTR_W-1:0] next_idx(input logic [PTR_W-1:0] p);
    if (p == PTR_W'(NUM_QUEUES - 1)) begin
      return '0;
    end
    return p + 1'b1;
  endfunction

  for (genvar i = 0; i < NUM_QUEUES; i++) begin : g_port
    assign gnt_vec[i] = mem_ready && (ptr == PTR_W'(i));  // one-hot by construction.
    assign req[i].available_read = gnt_vec[i];
    assign req_vec[i] = req[i].request_read;
    assign pend_vec[i] = req[i].has_pending;
    assign req_data[i] = req[i].request_data;
  end

  // a grant is known unused one cycle later, when no request followed it.
  assign unused_now = (gnt_q & ~req_vec) | (unused & ~gnt_q);
  assign cand = next_idx(ptr);
  assign cand_mask = NUM_QUEUES'(1) << cand;
  assign skip = unused_now[cand] && ((pend_vec & ~cand_mask) != '0);
  assign ptr_next = skip ? next_idx(cand) : cand;

  always_ff @(posedge clk) begin
    if (rst) begin
      ptr <= '0;
      gnt_q <= '0;
      unused <= '0;
    end else begin
      gnt_q <= gnt_vec;
      if (mem_ready) begin
        ptr <= ptr_next;
        unused <= skip ? (unused_now & ~cand_mask) : unused_now;  // skip only once.
      end else begin
        unused <= unused_now;
      end
    end
  end

  // ************************************************************
  // AND-OR mux of the granted request onto the memory port
  // ************************************************************
  always_comb begin
    req_mux = '0;
    for (int i = 0; i < NUM_QUEUES; i++) begin
      req_mux = req_mux | ({REQ_W{req_vec[i]}} & req_data[i]);
    end
  end

  assign mem_req_valid = |req_vec;
  assign mem_req_addr = req_mux[REQ_W-1 -: acc_pkg::ADDR_W];
  assign mem_req_tag = req_mux[acc_pkg::TAG_W-1:0];

endmodule

// File: read_subsystem.sv
`timescale 1ns/1ps

module read_subsystem #(
  parameter int NUM_QUEUES = 2,
  parameter int FIFO_DEPTH_BITS = 4
) (
  input  logic clk,
  input  logic rst,
  input  logic start,
  input  acc_pkg::conf_cmd_t conf_valid,
  input  acc_pkg::conf_t conf,
  input  logic mem_ready,
  input  logic rd_valid,
  input  acc_pkg::tag_t rd_tag,
  input  acc_pkg::data_t rd_data,
  input  logic [NUM_QUEUES-1:0] user_rd_en,
  output logic mem_req_valid,
  output acc_pkg::addr_t mem_req_addr,
  output acc_pkg::tag_t mem_req_tag,
  output logic [NUM_QUEUES-1:0] user_avail,
  output acc_pkg::data_t [NUM_QUEUES-1:0] user_data,
  output logic [NUM_QUEUES-1:0] user_valid,
  output logic done
);

  logic [NUM_QUEUES-1:0] done_vec;

  mem_rd_if rd_if [NUM_QUEUES] ();

  for (genvar i = 0; i < NUM_QUEUES; i++) begin : g_queue
    input_queue_controller #(
      .ID_QUEUE(i),
      .FIFO_DEPTH_BITS(FIFO_DEPTH_BITS)
    ) u_queue (
      .clk(clk),
      .rst(rst),
      .start(start),
      .conf_valid(conf_valid),
      .conf(conf),
      .rd_valid(rd_valid),
      .rd_tag(rd_tag),
      .rd_data(rd_data),
      .user_rd_en(user_rd_en[i]),
      .req(rd_if[i]),
      .user_avail(user_avail[i]),
      .user_data(user_data[i]),
      .user_valid(user_valid[i]),
      .done(done_vec[i])
    );
  end

  rd_req_arbiter #(
    .NUM_QUEUES(NUM_QUEUES)
  ) u_arb (
    .clk(clk),
    .rst(rst),
    .mem_ready(mem_ready),
    .req(rd_if),
    .mem_req_valid(mem_req_valid),
    .mem_req_addr(mem_req_addr),
    .mem_req_tag(mem_req_tag)
  );

  assign done = &done_vec;  // all queues have finished their runs.

endmodule

// File: read_subsystem_asserts.sv
`timescale 1ns/1ps

module read_subsystem_asserts #(
  parameter int NUM_QUEUES = 2
) (
  input logic clk,
  input logic rst,
  input logic mem_ready,
  input logic [NUM_QUEUES-1:0] gnt_vec,
  input logic [NUM_QUEUES-1:0] req_vec,
  input logic mem_req_valid
);

  int fail_count = 0;  // sampled by the testbench every cycle.

  // ************************************************************
  // grant and request rules of the arbiter
  // ************************************************************
  // a queue requests only in the cycle after its own grant.
  request_after_grant: assert property (@(posedge clk) disable iff (rst)
    (req_vec & ~$past(gnt_vec)) == '0)
    else begin
      $error("request_read without available_read in the cycle before");
      fail_count++;
    end

  request_onehot: assert property (@(posedge clk) disable iff (rst) $onehot0(req_vec))
    else begin
      $error("more than one queue raised request_read");
      fail_count++;
    end

  // no grant is given while memory is busy, so no request can follow.
  idle_no_request: assert property (@(posedge clk) disable iff (rst)
    !mem_ready |=> !mem_req_valid)
    else begin
      $error("mem_req_valid followed a cycle with mem_ready low");
      fail_count++;
    end

endmodule

bind rd_req_arbiter read_subsystem_asserts #(.NUM_QUEUES(NUM_QUEUES)) u_asserts (
  .clk(clk),
  .rst(rst),
  .mem_ready(mem_ready),
  .gnt_vec(gnt_vec),
  .req_vec(req_vec),
  .mem_req_valid(mem_req_valid)
);

// File: read_subsystem_cases.txt
# columns in hex: base0 qtd0 base1 qtd1 stray_id stray_base hold
# stray_id 00 sends no stray word, hold names the queue left undrained, ff for none
00001000 0008 00002000 0008 00 00000000 ff
00003000 0001 00004000 0003 05 00005000 ff
00010000 0020 00020000 0018 ff 00030000 00
0000a000 0030 0000b000 0004 02 0000c000 01
7ffffff0 0010 00100000 0028 80 00200000 ff
00400000 0040 00500000 0040 00 00000000 00
00600000 0005 00700000 0050 10 00800000 01
00900000 0013 00a00000 0011 03 00b00000 ff

// File: sync_fifo.sv
`timescale 1ns/1ps

module sync_fifo #(
  parameter int FIFO_DEPTH_BITS = 4,
  parameter int ALMOSTFULL_THRESHOLD = 12,
  parameter int ALMOSTEMPTY_THRESHOLD = 2
) (
  input  logic clk,
  input  logic rst,
  input  logic we,
  input  acc_pkg::data_t din,
  input  logic re,
  output logic valid,
  output acc_pkg::data_t dout,
  output logic [FIFO_DEPTH_BITS:0] count,
  output logic empty,
  output logic full,
  output logic almostfull,
  output logic almostempty
);

  localparam int DEPTH = 2 ** FIFO_DEPTH_BITS;

  acc_pkg::data_t mem [DEPTH];
  logic [FIFO_DEPTH_BITS-1:0] wr_ptr;
  logic [FIFO_DEPTH_BITS-1:0] rd_ptr;
  logic do_wr;
  logic do_rd;

  assign do_wr = we && !full;  // a write to a full FIFO is dropped.
  assign do_rd = re && !empty;

  assign empty = (count == '0);
  assign full = (count == DEPTH);
  assign almostfull = (count >= ALMOSTFULL_THRESHOLD);
  assign almostempty = (count <= ALMOSTEMPTY_THRESHOLD);

  always_ff @(posedge clk) begin
    if (do_wr) begin
      mem[wr_ptr] <= din;
    end
  end

  always_ff @(posedge clk) begin
    if (do_rd) begin
      dout <= mem[rd_ptr];  // registered read port.
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count <= '0;
      valid <= 1'b0;
    end else begin
      valid <= do_rd;
      if (do_wr) begin
        wr_ptr <= wr_ptr + 1'b1;  // pointers wrap at the depth.
      end
      if (do_rd) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({do_wr, do_rd})
        2'b10: count <= count + 1'b1;
        2'b01: count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

// File: tb_read_subsystem.sv
`timescale 1ns/1ps

module tb_read_subsystem;

  localparam int NQ = 2;
  localparam int HOLD_CYCLES = 150;
  localparam int MAX_CASES = 32;

  logic clk;
  logic rst;
  logic start;
  acc_pkg::conf_cmd_t conf_valid;
  acc_pkg::conf_t conf;
  logic mem_ready;
  logic rd_valid;
  acc_pkg::tag_t rd_tag;
  acc_pkg::data_t rd_data;
  logic [NQ-1:0] user_rd_en;
  logic mem_req_valid;
  acc_pkg::addr_t mem_req_addr;
  acc_pkg::tag_t mem_req_tag;
  logic [NQ-1:0] user_avail;
  acc_pkg::data_t [NQ-1:0] user_data;
  logic [NQ-1:0] user_valid;
  logic done;

  acc_pkg::addr_t case_base [MAX_CASES][NQ];
  acc_pkg::qtd_t case_qtd [MAX_CASES][NQ];
  acc_pkg::qid_t case_stray_id [MAX_CASES];
  acc_pkg::addr_t case_stray_base [MAX_CASES];
  logic [7:0] case_hold [MAX_CASES];
  int num_cases;
  int limit_cycles;
  acc_pkg::addr_t base [NQ];
  acc_pkg::qtd_t qtd [NQ];
  int req_cnt [NQ];
  int rd_cnt [NQ];
  int sent [NQ];
  int sent_prev [NQ];
  int fifo_in [NQ];
  int hold_q;
  int run_cycles;
  longint cycle_no;
  longint last_due;
  acc_pkg::addr_t mq_addr [$];
  acc_pkg::tag_t mq_tag [$];
  longint mq_due [$];
  logic [31:0] lfsr_state;

  read_subsystem #(
    .NUM_QUEUES(NQ),
    .FIFO_DEPTH_BITS(4)
  ) u_dut (
    .clk(clk),
    .rst(rst),
    .start(start),
    .conf_valid(conf_valid),
    .conf(conf),
    .mem_ready(mem_ready),
    .rd_valid(rd_valid),
    .rd_tag(rd_tag),
    .rd_data(rd_data),
    .user_rd_en(user_rd_en),
    .mem_req_valid(mem_req_valid),
    .mem_req_addr(mem_req_addr),
    .mem_req_tag(mem_req_tag),
    .user_avail(user_avail),
    .user_data(user_data),
    .user_valid(user_valid),
    .done(done)
  );

  always #5 clk = ~clk;

  // ************************************************************
  // error reporting and compare tasks
  // ************************************************************
  task automatic stop_on_error();
    $display("Verification failed");
    $fatal(1, "stopping at the first error");
  endtask

  task automatic report_error(input string why);
    $display("Error at %0t ns: %s", $time, why);
    stop_on_error();
  endtask

  task automatic check_data(input string name, input acc_pkg::data_t got,
                            input acc_pkg::data_t exp);
    if (got !== exp) begin
      $display("Fail at %0t ns: %s is %h, expected %h", $time, name, got, exp);
      stop_on_error();
    end
  endtask

  task automatic check_addr(input string name, input acc_pkg::addr_t got,
                            input acc_pkg::addr_t exp);
    if (got !== exp) begin
      $display("Fail at %0t ns: %s is %h, expected %h", $time, name, got, exp);
      stop_on_error();
    end
  endtask

  task automatic check_tag(input string name, input acc_pkg::tag_t got,
                           input acc_pkg::tag_t exp);
    if (got !== exp) begin
      $display("Fail at %0t ns: %s is %h, expected %h", $time, name, got, exp);
      stop_on_error();
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("Fail at %0t ns: %s is %b, expected %b", $time, name, got, exp);
      stop_on_error();
    end
  endtask

  // galois lfsr, one step per bit taken.
  function automatic logic [7:0] random_bits(input int n);
    logic [7:0] val;
    val = '0;
    for (int k = 0; k < n; k++) begin
      val = {val[6:0], lfsr_state[0]};
      lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'h8020_0003) : (lfsr_state >> 1);
    end
    return val;
  endfunction

  function automatic acc_pkg::data_t line_of(input acc_pkg::addr_t a);
    return {a, ~a};  // the memory returns the address above its inverse.
  endfunction

  function automatic int owner_of(input acc_pkg::addr_t a);
    for (int q = 0; q < NQ; q++) begin
      if (a >= base[q] && (a - base[q]) < qtd[q]) begin
        return q;
      end
    end
    return -1;
  endfunction

  task automatic load_cases();
    int fd;
    int fields;
    int total;
    logic [8*160-1:0] text;
    fd = $fopen("read_subsystem_cases.txt", "r");
    if (fd == 0) begin
      report_error("cannot open read_subsystem_cases.txt");
    end
    num_cases = 0;
    total = 0;
    while ($fgets(text, fd) != 0 && num_cases < MAX_CASES) begin
      fields = $sscanf(text, "%h %h %h %h %h %h %h", case_base[num_cases][0],
                       case_qtd[num_cases][0], case_base[num_cases][1], case_qtd[num_cases][1],
                       case_stray_id[num_cases], case_stray_base[num_cases],
                       case_hold[num_cases]);
      if (fields == 7) begin
        total += case_qtd[num_cases][0] + case_qtd[num_cases][1];
        num_cases++;
      end
    end
    $fclose(fd);
    if (num_cases == 0) begin
      report_error("the cases file holds no test case");
    end
    limit_cycles = 40 * total + 200 * num_cases;  // margin for reset, setup and the pause.
  endtask

  // ************************************************************
  // one clock cycle: memory model, user drain and checks
  // ************************************************************
  task automatic step_cycle();
    int own;
    longint due;
    int level;
    @(posedge clk);
    #1;
    cycle_no++;
    if (u_dut.u_arb.u_asserts.fail_count != 0) begin
      report_error("an arbiter assertion fired");
    end
    // a response reaches the FIFO two edges after it is driven.
    for (int q = 0; q < NQ; q++) begin
      fifo_in[q] = sent_prev[q];
      sent_prev[q] = sent[q];
    end
    if (mq_addr.size() > 0 && mq_due[0] <= cycle_no) begin
      rd_valid = 1'b1;
      rd_tag = mq_tag[0];
      rd_data = line_of(mq_addr[0]);
      sent[int'(mq_tag[0])]++;
      void'(mq_addr.pop_front());
      void'(mq_tag.pop_front());
      void'(mq_due.pop_front());
    end else begin
      rd_valid = 1'b0;
      rd_tag = '0;
      rd_data = '0;
    end
    if (!mem_ready) begin
      check_bit("mem_req_valid", mem_req_valid, 1'b0);
    end
    if (mem_req_valid) begin
      own = owner_of(mem_req_addr);
      if (own < 0) begin
        report_error($sformatf("request for address %h, which no queue owns", mem_req_addr));
      end
      check_tag("mem_req_tag", mem_req_tag, acc_pkg::tag_t'(own));
      check_addr("mem_req_addr", mem_req_addr, base[own] + acc_pkg::addr_t'(req_cnt[own]));
      req_cnt[own]++;
      due = cycle_no + 2 + random_bits(2);
      if (due <= last_due) begin
        due = last_due + 1;  // responses stay in order.
      end
      last_due = due;
      mq_addr.push_back(mem_req_addr);
      mq_tag.push_back(mem_req_tag);
      mq_due.push_back(due);
    end
    for (int q = 0; q < NQ; q++) begin
      check_bit($sformatf("user_valid[%0d]", q), user_valid[q], user_rd_en[q]);
      if (user_valid[q]) begin
        if (rd_cnt[q] >= qtd[q]) begin
          report_error($sformatf("queue %0d delivered more than %0d lines", q, qtd[q]));
        end
        check_data($sformatf("user_data[%0d]", q), user_data[q],
                   line_of(base[q] + acc_pkg::addr_t'(rd_cnt[q])));
        rd_cnt[q]++;
      end
      level = fifo_in[q] - rd_cnt[q];
      check_bit($sformatf("user_avail[%0d]", q), user_avail[q],
                level > 2 || (level > 0 && !user_rd_en[q]));
      if (req_cnt[q] - rd_cnt[q] > 16) begin
        report_error($sformatf("queue %0d holds more than 16 lines in flight", q));
      end
    end
    if (!start || sent[0] < qtd[0] || sent[1] < qtd[1]) begin
      check_bit("done", done, 1'b0);
    end
    if (start) begin
      run_cycles++;
    end
    mem_ready = (random_bits(2) != 0);
    for (int q = 0; q < NQ; q++) begin
      user_rd_en[q] = start && !(q == hold_q && run_cycles < HOLD_CYCLES) && user_avail[q] &&
                      (random_bits(1) != 0);
    end
  endtask

  task automatic send_conf(input acc_pkg::qid_t id, input acc_pkg::addr_t a,
                           input acc_pkg::qtd_t n);
    conf_valid = acc_pkg::CONF_LOAD;
    conf = {a, n, id};
    step_cycle();
    conf_valid = '0;
    step_cycle();
  endtask

  task automatic run_case(input int i);
    rst = 1'b1;
    start = 1'b0;
    for (int q = 0; q < NQ; q++) begin
      base[q] = case_base[i][q];
      qtd[q] = case_qtd[i][q];
      req_cnt[q] = 0;
      rd_cnt[q] = 0;
      sent[q] = 0;
      sent_prev[q] = 0;
      fifo_in[q] = 0;
    end
    hold_q = (case_hold[i] < NQ) ? int'(case_hold[i]) : -1;
    run_cycles = 0;
    mq_addr.delete();
    mq_tag.delete();
    mq_due.delete();
    last_due = 0;
    repeat (2) step_cycle();
    rst = 1'b0;
    send_conf(8'd0, base[0], qtd[0]);
    send_conf(8'd1, base[1], qtd[1]);
    if (case_stray_id[i] != 0) begin
      send_conf(case_stray_id[i], case_stray_base[i], 16'd16);
    end
    repeat (6) step_cycle();
    start = 1'b1;
    while (!(rd_cnt[0] == qtd[0] && rd_cnt[1] == qtd[1] && done)) begin
      step_cycle();
    end
    repeat (10) step_cycle();  // nothing may follow the last line.
  endtask

  initial begin
    wait (limit_cycles > 0);
    repeat (limit_cycles) @(posedge clk);
    report_error("watchdog expired before all cases finished");
  end

  initial begin
    clk = 1'b0;
    rst = 1'b1;
    start = 1'b0;
    conf_valid = '0;
    conf = '0;
    mem_ready = 1'b0;
    rd_valid = 1'b0;
    rd_tag = '0;
    rd_data = '0;
    user_rd_en = '0;
    cycle_no = 0;
    lfsr_state = 32'd66170;
    load_cases();
    for (int i = 0; i < num_cases; i++) begin
      run_case(i);
    end
    $display("Verification passed");
    $finish;
  end

endmodule

// File: verilog.f
acc_pkg.sv
mem_rd_if.sv
sync_fifo.sv
input_queue_controller.sv
rd_req_arbiter.sv
read_subsystem.sv
read_subsystem_asserts.sv
tb_read_subsystem.sv
